//--- compile.f
src/ahb_lite_pkg.sv
src/mem_map_pkg.sv
src/dual_port_sram.sv
src/mem_port_bridge.sv
src/main_memory.sv
verification/main_memory_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the main memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f compile.f \
  --top-module main_memory_tb \
  -o main_memory_tb

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/main_memory_tb

//--- verification/main_memory_tb.sv
// main memory testbench with clocks, reset, step table, word model, checker and pass/fail
`timescale 1ns/1ps

module main_memory_tb
  import ahb_lite_pkg::*;
  import mem_map_pkg::*;
;

  // clk_l2 cycles allowed for one transfer
  localparam int WAIT_LIMIT = 60;

  // clk_l2 cycles for an earlier req/ack handshake to release the port
  localparam int RELEASE_CYCLES = 8;

  typedef struct packed {
    bit     is_dmem;
    bit     write;
    haddr_t addr;
    hdata_t wdata;
    hdata_t exp_data;
    logic   exp_resp;
    // run together with the following step
    bit     with_next;
  } step_t;

  logic   clk_l2;
  logic   clk_mem;
  logic   rst_n;
  logic   imem_hsel;
  haddr_t imem_haddr;
  hdata_t imem_hrdata;
  logic   imem_hreadyout;
  logic   imem_hresp;
  logic   dmem_hsel;
  haddr_t dmem_haddr;
  logic   dmem_hwrite;
  hdata_t dmem_hwdata;
  hdata_t dmem_hrdata;
  logic   dmem_hreadyout;
  logic   dmem_hresp;

  // expected memory contents
  hdata_t model [MEM_WORDS];
  step_t  steps [$];
  integer seed;

  main_memory dut (
    .clk_l2         (clk_l2),
    .clk_mem        (clk_mem),
    .rst_n          (rst_n),
    .imem_hsel      (imem_hsel),
    .imem_haddr     (imem_haddr),
    .imem_hrdata    (imem_hrdata),
    .imem_hreadyout (imem_hreadyout),
    .imem_hresp     (imem_hresp),
    .dmem_hsel      (dmem_hsel),
    .dmem_haddr     (dmem_haddr),
    .dmem_hwrite    (dmem_hwrite),
    .dmem_hwdata    (dmem_hwdata),
    .dmem_hrdata    (dmem_hrdata),
    .dmem_hreadyout (dmem_hreadyout),
    .dmem_hresp     (dmem_hresp)
  );

  // --------------------
  // clocks
  // --------------------

  // 40 ns bus clock and unrelated 30 ns memory clock
  initial clk_l2 = 1'b0;
  always #20 clk_l2 = ~clk_l2;

  initial clk_mem = 1'b0;
  always #15 clk_mem = ~clk_mem;

  // --------------------
  // checker and model
  // --------------------

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  // table entry with expected values from the address rule and the model
  task automatic add_step(input bit is_dmem, input bit write, input haddr_t addr,
                          input hdata_t wdata, input bit with_next);
    step_t       s;
    word_index_t idx;
    bit          in_range;
    in_range   = (addr[1:0] == 2'b00) && (addr < MEM_BYTES);
    idx        = addr[11:2];
    s.is_dmem  = is_dmem;
    s.write    = write;
    s.addr     = addr;
    s.wdata    = wdata;
    s.with_next = with_next;
    s.exp_resp = in_range ? HRESP_OKAY : HRESP_ERROR;
    s.exp_data = '0;
    if (in_range && write)
      model[idx] = wdata;
    else if (in_range)
      s.exp_data = model[idx];
    steps.push_back(s);
  endtask

  task automatic build_table();
    haddr_t pairs [5];
    hdata_t word;
    pairs = '{32'h0000_0000, 32'h0000_0ffc, 32'h0000_0040, 32'h0000_048c, 32'h0000_0800};
    // write then read back over several words incl first and last
    foreach (pairs[k])
    begin
      word = $random(seed);
      add_step(1'b1, 1'b1, pairs[k], word, 1'b0);
      add_step(1'b1, 1'b0, pairs[k], '0, 1'b0);
    end
    // instruction port sees data port writes
    add_step(1'b0, 1'b0, 32'h0000_0040, '0, 1'b0);
    add_step(1'b0, 1'b0, 32'h0000_0ffc, '0, 1'b0);
    // bad data writes leave the neighbour word alone
    add_step(1'b1, 1'b1, 32'h0000_0042, $random(seed), 1'b0);
    add_step(1'b1, 1'b0, 32'h0000_0040, '0, 1'b0);
    add_step(1'b1, 1'b1, MEM_BYTES, $random(seed), 1'b0);
    add_step(1'b1, 1'b0, 32'h0000_0ffc, '0, 1'b0);
    // out of range index would wrap onto word 0
    add_step(1'b1, 1'b0, 32'h0000_0000, '0, 1'b0);
    add_step(1'b1, 1'b0, 32'h0000_0801, '0, 1'b0);
    // instruction port errors
    add_step(1'b0, 1'b0, 32'h0000_0006, '0, 1'b0);
    add_step(1'b0, 1'b0, 32'h0000_2000, '0, 1'b0);
    // both ports in one cycle and a data read to confirm the write
    add_step(1'b0, 1'b0, 32'h0000_0800, '0, 1'b1);
    add_step(1'b1, 1'b1, 32'h0000_0200, $random(seed), 1'b0);
    add_step(1'b1, 1'b0, 32'h0000_0200, '0, 1'b0);
  endtask

  // --------------------
  // one bus transfer
  // --------------------

  task automatic run_step(input step_t s);
    int     n;
    logic   ready;
    logic   resp;
    hdata_t rdata;
    n     = 0;
    ready = 1'b0;
    // error answer comes only from an idle bridge
    if (s.exp_resp == HRESP_ERROR)
      repeat (RELEASE_CYCLES) @(posedge clk_l2);
    @(posedge clk_l2);
    if (s.is_dmem)
    begin
      dmem_hsel   <= 1'b1;
      dmem_haddr  <= s.addr;
      dmem_hwrite <= s.write;
      dmem_hwdata <= s.wdata;
    end
    else
    begin
      imem_hsel  <= 1'b1;
      imem_haddr <= s.addr;
    end
    // outputs sampled mid cycle
    while (!ready)
    begin
      if (n == WAIT_LIMIT)
      begin
        $display("timeout: %s port gave no hreadyout for address %h",
                 s.is_dmem ? "data" : "instruction", s.addr);
        $display("CHECKS FAILED");
        $fatal(1);
      end
      @(negedge clk_l2);
      n++;
      ready = s.is_dmem ? dmem_hreadyout : imem_hreadyout;
    end
    rdata = s.is_dmem ? dmem_hrdata : imem_hrdata;
    resp  = s.is_dmem ? dmem_hresp : imem_hresp;
    // drop hsel on the edge after the pulse
    @(posedge clk_l2);
    if (s.is_dmem)
      dmem_hsel <= 1'b0;
    else
      imem_hsel <= 1'b0;
    @(negedge clk_l2);
    ready = s.is_dmem ? dmem_hreadyout : imem_hreadyout;
    check_value(32'(ready), 32'd0, "hreadyout longer than one cycle");
    check_value(32'(resp), 32'(s.exp_resp), "hresp");
    // error pulse lands in the cycle after hsel rises
    if (s.exp_resp == HRESP_ERROR)
      check_value(n, 32'd2, "error response latency");
    else if (!s.write)
      check_value(rdata, s.exp_data, "hrdata");
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial
  begin
    step_t a;
    step_t b;
    int    i;
    seed        = 32'hf03c_20f4;
    rst_n       <= 1'b0;
    imem_hsel   <= 1'b0;
    imem_haddr  <= '0;
    dmem_hsel   <= 1'b0;
    dmem_haddr  <= '0;
    dmem_hwrite <= 1'b0;
    dmem_hwdata <= '0;
    build_table();
    repeat (8) @(posedge clk_l2);
    rst_n <= 1'b1;
    // quiet outputs while no port is selected
    repeat (6)
    begin
      @(negedge clk_l2);
      check_value(32'(imem_hreadyout), 32'd0, "imem hreadyout after reset");
      check_value(32'(imem_hresp), 32'd0, "imem hresp after reset");
      check_value(imem_hrdata, 32'd0, "imem hrdata after reset");
      check_value(32'(dmem_hreadyout), 32'd0, "dmem hreadyout after reset");
      check_value(32'(dmem_hresp), 32'd0, "dmem hresp after reset");
      check_value(dmem_hrdata, 32'd0, "dmem hrdata after reset");
    end
    i = 0;
    while (i < steps.size())
    begin
      a = steps[i];
      if (a.with_next)
      begin
        b = steps[i+1];
        fork
          run_step(a);
          run_step(b);
        join
        i = i + 2;
      end
      else
      begin
        run_step(a);
        i = i + 1;
      end
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- src/main_memory.sv
// main memory top: instruction and data port bridges sharing one dual-port sram
`timescale 1ns/1ps

module main_memory
  import ahb_lite_pkg::*;
  import mem_map_pkg::*;
(
  input  logic   clk_l2,
  input  logic   clk_mem,
  input  logic   rst_n,
  // instruction port, read only
  input  logic   imem_hsel,
  input  haddr_t imem_haddr,
  output hdata_t imem_hrdata,
  output logic   imem_hreadyout,
  output logic   imem_hresp,
  // data port
  input  logic   dmem_hsel,
  input  haddr_t dmem_haddr,
  input  logic   dmem_hwrite,
  input  hdata_t dmem_hwdata,
  output hdata_t dmem_hrdata,
  output logic   dmem_hreadyout,
  output logic   dmem_hresp
);

  // --------------------
  // bridge to sram wires
  // --------------------

  word_index_t imem_sram_index;
  hdata_t      imem_sram_rdata;

  word_index_t dmem_sram_index;
  logic        dmem_sram_wen;
  hdata_t      dmem_sram_wdata;
  hdata_t      dmem_sram_rdata;

  // instruction fetch path, write side tied off
  mem_port_bridge #(
    .HAS_WRITE (1'b0)
  ) u_imem_bridge (
    .clk_l2     (clk_l2),
    .clk_mem    (clk_mem),
    .rst_n      (rst_n),
    .hsel       (imem_hsel),
    .haddr      (imem_haddr),
    .hwrite     (1'b0),
    .hwdata     ('0),
    .hrdata     (imem_hrdata),
    .hreadyout  (imem_hreadyout),
    .hresp      (imem_hresp),
    .sram_index (imem_sram_index),
    .sram_wen   (),
    .sram_wdata (),
    .sram_rdata (imem_sram_rdata)
  );

  // load/store path
  mem_port_bridge #(
    .HAS_WRITE (1'b1)
  ) u_dmem_bridge (
    .clk_l2     (clk_l2),
    .clk_mem    (clk_mem),
    .rst_n      (rst_n),
    .hsel       (dmem_hsel),
    .haddr      (dmem_haddr),
    .hwrite     (dmem_hwrite),
    .hwdata     (dmem_hwdata),
    .hrdata     (dmem_hrdata),
    .hreadyout  (dmem_hreadyout),
    .hresp      (dmem_hresp),
    .sram_index (dmem_sram_index),
    .sram_wen   (dmem_sram_wen),
    .sram_wdata (dmem_sram_wdata),
    .sram_rdata (dmem_sram_rdata)
  );

  // shared storage, imem on the read port
  dual_port_sram u_sram (
    .clk_mem  (clk_mem),
    .rd_index (imem_sram_index),
    .rd_data  (imem_sram_rdata),
    .rw_index (dmem_sram_index),
    .rw_wen   (dmem_sram_wen),
    .rw_wdata (dmem_sram_wdata),
    .rw_data  (dmem_sram_rdata)
  );

endmodule

//--- src/mem_port_bridge.sv
// bus port bridge: clk_l2 request FSM, clk_mem access FSM, req/ack synchronizers
`timescale 1ns/1ps

module mem_port_bridge
  import ahb_lite_pkg::*;
  import mem_map_pkg::*;
#(
  parameter bit HAS_WRITE = 1'b1
)
(
  input  logic        clk_l2,
  input  logic        clk_mem,
  input  logic        rst_n,
  // bus side
  input  logic        hsel,
  input  haddr_t      haddr,
  input  logic        hwrite,
  input  hdata_t      hwdata,
  output hdata_t      hrdata,
  output logic        hreadyout,
  output logic        hresp,
  // sram side
  output word_index_t sram_index,
  output logic        sram_wen,
  output hdata_t      sram_wdata,
  input  hdata_t      sram_rdata
);

  typedef enum logic [1:0] {
    L2_IDLE,
    L2_WAIT_ACK,
    L2_WAIT_RELEASE
  } l2_state_t;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_ACCESS,
    MEM_ACK
  } mem_state_t;

  l2_state_t   l2_state;
  mem_state_t  mem_state;

  // request level from clk_l2, ack level from clk_mem
  logic        req_l2;
  logic        ack_mem;

  // two-flop synchronizers
  logic        req_meta;
  logic        req_sync;
  logic        ack_meta;
  logic        ack_sync;

  // captured request, stable while req_l2 is high
  word_index_t index_l2;
  logic        write_l2;
  hdata_t      wdata_l2;

  // read word held for the clk_l2 side
  hdata_t      rdata_hold;

  // --------------------
  // clk_l2 side
  // --------------------

  // ack into the bus clock
  always_ff @(posedge clk_l2 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
    end
    else
    begin
      ack_meta <= ack_mem;
      ack_sync <= ack_meta;
    end
  end

  always_ff @(posedge clk_l2 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      l2_state  <= L2_IDLE;
      req_l2    <= 1'b0;
      hreadyout <= 1'b0;
      hresp     <= HRESP_OKAY;
      hrdata    <= '0;
    end
    else
    begin
      // pulses by default
      hreadyout <= 1'b0;
      hresp     <= HRESP_OKAY;
      case (l2_state)
        L2_IDLE:
        begin
          // hsel still high in the cycle after a pulse, so skip it
          if (hsel && !hreadyout && !ack_sync)
          begin
            if (addr_in_range(haddr))
            begin
              req_l2   <= 1'b1;
              l2_state <= L2_WAIT_ACK;
            end
            else
            begin
              // error answer, sram untouched
              hreadyout <= 1'b1;
              hresp     <= HRESP_ERROR;
            end
          end
        end
        L2_WAIT_ACK:
        begin
          if (ack_sync)
          begin
            // rdata_hold is frozen while ack_mem is high
            hrdata    <= rdata_hold;
            hreadyout <= 1'b1;
            req_l2    <= 1'b0;
            l2_state  <= L2_WAIT_RELEASE;
          end
        end
        L2_WAIT_RELEASE:
        begin
          // handshake must close before next request
          if (!ack_sync)
            l2_state <= L2_IDLE;
        end
        default:
          l2_state <= L2_IDLE;
      endcase
    end
  end

  // request payload capture
  always_ff @(posedge clk_l2)
  begin
    if (l2_state == L2_IDLE && hsel && !hreadyout && !ack_sync)
    begin
      index_l2 <= addr_word_index(haddr);
      write_l2 <= HAS_WRITE && hwrite;
      wdata_l2 <= hwdata;
    end
  end

  // --------------------
  // clk_mem side
  // --------------------

  // request into the memory clock
  always_ff @(posedge clk_mem or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_meta <= 1'b0;
      req_sync <= 1'b0;
    end
    else
    begin
      req_meta <= req_l2;
      req_sync <= req_meta;
    end
  end

  always_ff @(posedge clk_mem or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mem_state <= MEM_IDLE;
      sram_wen  <= 1'b0;
      ack_mem   <= 1'b0;
    end
    else
    begin
      case (mem_state)
        MEM_IDLE:
        begin
          if (req_sync)
          begin
            // write enable for exactly one clk_mem cycle
            sram_wen  <= HAS_WRITE && write_l2;
            mem_state <= MEM_ACCESS;
          end
        end
        MEM_ACCESS:
        begin
          // sram samples now, read word arrives next cycle
          sram_wen  <= 1'b0;
          mem_state <= MEM_ACK;
        end
        MEM_ACK:
        begin
          if (!ack_mem)
            ack_mem <= 1'b1;
          else if (!req_sync)
          begin
            ack_mem   <= 1'b0;
            mem_state <= MEM_IDLE;
          end
        end
        default:
          mem_state <= MEM_IDLE;
      endcase
    end
  end

  // payload into sram, taken once req_sync is seen
  always_ff @(posedge clk_mem)
  begin
    if (mem_state == MEM_IDLE && req_sync)
    begin
      sram_index <= index_l2;
      sram_wdata <= wdata_l2;
    end
    // read word latched once, kept through ack high
    if (mem_state == MEM_ACK && !ack_mem)
      rdata_hold <= sram_rdata;
  end

endmodule

//--- src/dual_port_sram.sv
// dual-port word memory: read port plus read/write port, registered reads
`timescale 1ns/1ps

module dual_port_sram
  import ahb_lite_pkg::*;
  import mem_map_pkg::*;
(
  input  logic        clk_mem,
  // read-only port
  input  word_index_t rd_index,
  output hdata_t      rd_data,
  // read/write port
  input  word_index_t rw_index,
  input  logic        rw_wen,
  input  hdata_t      rw_wdata,
  output hdata_t      rw_data
);

  // --------------------
  // storage
  // --------------------

  // contents undefined until written
  hdata_t mem [MEM_WORDS];

  // --------------------
  // read port
  // --------------------

  // registered read every cycle
  always_ff @(posedge clk_mem)
  begin
    rd_data <= mem[rd_index];
  end

  // --------------------
  // read/write port
  // --------------------

  // old word comes out on a write
  always_ff @(posedge clk_mem)
  begin
    rw_data <= mem[rw_index];
    if (rw_wen)
      mem[rw_index] <= rw_wdata;
  end

endmodule

//--- src/mem_map_pkg.sv
// memory depth, word index type, address range check and index extraction
package mem_map_pkg;

  import ahb_lite_pkg::*;

  // depth in words
  localparam int unsigned MEM_WORDS = 1024;

  // index width follows the depth
  localparam int WORD_INDEX_W = $clog2(MEM_WORDS);

  // byte span covered by the memory
  localparam int unsigned MEM_BYTES = MEM_WORDS * 4;

  // sram word index
  typedef logic [WORD_INDEX_W-1:0] word_index_t;

  // in range means word aligned and below the byte span
  function automatic logic addr_in_range(haddr_t addr);
    return (addr[1:0] == 2'b00) && (addr < haddr_t'(MEM_BYTES));
  endfunction

  // word index sits just above the two byte-offset bits
  function automatic word_index_t addr_word_index(haddr_t addr);
    return addr[WORD_INDEX_W+1:2];
  endfunction

endpackage

//--- src/ahb_lite_pkg.sv
// bus-side address and data types, hresp encoding
package ahb_lite_pkg;

  // --------------------
  // bus widths
  // --------------------

  // byte address on the bus
  localparam int HADDR_W = 32;

  // one bus data word
  localparam int HDATA_W = 32;

  // --------------------
  // types
  // --------------------

  // byte address as driven by the master
  typedef logic [HADDR_W-1:0] haddr_t;

  // read or write data word
  typedef logic [HDATA_W-1:0] hdata_t;

  // --------------------
  // response encoding
  // --------------------

  // one-bit hresp, okay for normal completion
  localparam logic HRESP_OKAY  = 1'b0;
  // error for misaligned or out of range access
  localparam logic HRESP_ERROR = 1'b1;

endpackage
